// ==== ddr3_ctrl_params.svh ====
`ifndef DDR3_CTRL_PARAMS_SVH
`define DDR3_CTRL_PARAMS_SVH

// ----------------------------------------------------------
// Geometry
// ----------------------------------------------------------
`define DDR_COL_W           10
`define DDR_BANK_W          3
// Row width doubles as address bus width
`define DDR_ROW_W           15
`define DDR_BANKS           8
`define DDR_ADDR_W          32

// ----------------------------------------------------------
// Timer, scaled down for simulation
// ----------------------------------------------------------
`define DDR_TIMER_W         20
`define DDR_START_DELAY     2600
`define DDR_REFRESH_CYCLES  400

// Init step offsets, compared against the down-count
`define DDR_CKE_COUNT       2500
`define DDR_MR2_COUNT       2400
`define DDR_MR3_COUNT       2300
`define DDR_MR1_COUNT       2200
`define DDR_MR0_COUNT       2100
`define DDR_ZQCL_COUNT      2000
`define DDR_PREA_COUNT      10

// Mode registers: DLL off, CL 6, AL 0, CWL 6
`define DDR_MR0_VAL         15'h0120
`define DDR_MR1_VAL         15'h0001
`define DDR_MR2_VAL         15'h0008
`define DDR_MR3_VAL         15'h0000

// All-banks on precharge, auto-precharge on read/write
`define DDR_A10             10

`endif

// ==== ddr3_ctrl_pkg.sv ====
`include "ddr3_ctrl_params.svh"

package ddr3_ctrl_pkg;

  // ----------------------------------------------------------
  // Encodings
  // ----------------------------------------------------------
  // Command as {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_LOAD_MODE = 4'b0000,
    CMD_REFRESH   = 4'b0001,
    CMD_PRECHARGE = 4'b0010,
    CMD_ACTIVE    = 4'b0011,
    CMD_WRITE     = 4'b0100,
    CMD_READ      = 4'b0101,
    CMD_ZQCL      = 4'b0110,
    CMD_NOP       = 4'b0111
  } ddr_cmd_e;

  // Scheduler states
  typedef enum logic [2:0] {
    STATE_INIT      = 3'd0,
    STATE_IDLE      = 3'd1,
    STATE_ACTIVATE  = 3'd2,
    STATE_READ      = 3'd3,
    STATE_WRITE     = 3'd4,
    STATE_PRECHARGE = 3'd5,
    STATE_REFRESH   = 3'd6
  } ctrl_state_e;

  // ----------------------------------------------------------
  // Bundles
  // ----------------------------------------------------------
  // Command toward the DFI sequencer
  typedef struct packed {
    logic                   cke;
    ddr_cmd_e               command;
    logic [`DDR_BANK_W-1:0] bank;
    logic [`DDR_ROW_W-1:0]  address;
  } dfi_cmd_t;

  // Decoded request address plus open-row lookup
  typedef struct packed {
    logic [`DDR_ROW_W-1:0]  row;
    logic [`DDR_BANK_W-1:0] bank;
    logic [`DDR_COL_W-1:0]  col;
    logic                   bank_open;
    logic                   row_hit;
    logic                   any_open;
  } bank_status_t;

  // One-cycle strobes on accepted commands
  typedef struct packed {
    logic activate;
    logic close_one;
    logic close_all;
  } bank_update_t;

  typedef struct packed {
    logic [`DDR_TIMER_W-1:0] count;
    logic                    pending;
  } refresh_status_t;

endpackage

// ==== ddr3_refresh_timer.sv ====
`timescale 1ns/100ps
`include "ddr3_ctrl_params.svh"

module ddr3_refresh_timer (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            refresh_done_i,
  output ddr3_ctrl_pkg::refresh_status_t  status_o
);

  // ----------------------------------------------------------
  // Load values
  // ----------------------------------------------------------
  // Power-up wait, then one refresh per interval
  localparam logic [`DDR_TIMER_W-1:0] START_LOAD   = `DDR_START_DELAY;
  localparam logic [`DDR_TIMER_W-1:0] REFRESH_LOAD = `DDR_REFRESH_CYCLES;

  logic [`DDR_TIMER_W-1:0] count_q;
  logic                    pending_q;
  logic                    expired;

  // Terminal count
  assign expired = (count_q == '0);

  // ----------------------------------------------------------
  // Down-counter
  // ----------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      count_q <= START_LOAD;
    end else if (expired) begin
      // Wrap into the periodic interval
      count_q <= REFRESH_LOAD;
    end else begin
      count_q <= count_q - 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Pending flag
  // ----------------------------------------------------------
  // Set one cycle after zero, held until the REFRESH is taken
  always_ff @(posedge clock) begin
    if (reset) begin
      pending_q <= 1'b0;
    end else if (expired) begin
      pending_q <= 1'b1;
    end else if (refresh_done_i) begin
      pending_q <= 1'b0;
    end
  end

  // Count also feeds the init decode in the FSM
  always_comb begin
    status_o.count   = count_q;
    status_o.pending = pending_q;
  end

  // FSM may only retire a refresh that this timer requested
  a_done_needs_pending : assert property (
    @(posedge clock) disable iff (reset)
    refresh_done_i |-> pending_q
  ) else $error("%0t refresh_done_i: expected pending 1, got %b", $time, pending_q);

endmodule

// ==== ddr3_bank_tracker.sv ====
`timescale 1ns/100ps
`include "ddr3_ctrl_params.svh"

module ddr3_bank_tracker (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          cfg_enable_i,
  input  logic [`DDR_ADDR_W-1:0]        mem_addr_i,
  input  ddr3_ctrl_pkg::bank_update_t   update_i,
  output ddr3_ctrl_pkg::bank_status_t   status_o
);

  // ----------------------------------------------------------
  // RBC address layout
  // ----------------------------------------------------------
  // Column sits above the byte offset, bank above column
  localparam int BANK_LSB = `DDR_COL_W + 1;
  localparam int ROW_LSB  = BANK_LSB + `DDR_BANK_W;

  logic [`DDR_ROW_W-1:0]  addr_row;
  logic [`DDR_BANK_W-1:0] addr_bank;
  logic [`DDR_COL_W-1:0]  addr_col;

  assign addr_row  = mem_addr_i[ROW_LSB +: `DDR_ROW_W];
  assign addr_bank = mem_addr_i[BANK_LSB +: `DDR_BANK_W];
  // Burst of 8, low three column bits forced to zero
  assign addr_col  = {mem_addr_i[`DDR_COL_W:4], 3'b000};

  // ----------------------------------------------------------
  // Open-row table
  // ----------------------------------------------------------
  logic [`DDR_ROW_W-1:0] row_q [`DDR_BANKS];
  logic [`DDR_BANKS-1:0] open_q;

  // Open flags; disable forgets every row
  always_ff @(posedge clock) begin
    if (reset || !cfg_enable_i) begin
      open_q <= '0;
    end else if (update_i.close_all) begin
      open_q <= '0;
    end else if (update_i.close_one) begin
      open_q[addr_bank] <= 1'b0;
    end else if (update_i.activate) begin
      open_q[addr_bank] <= 1'b1;
    end
  end

  // Row numbers only mean something while the flag is set
  always_ff @(posedge clock) begin
    if (update_i.activate) begin
      row_q[addr_bank] <= addr_row;
    end
  end

  // ----------------------------------------------------------
  // Status toward the FSM
  // ----------------------------------------------------------
  always_comb begin
    status_o.row       = addr_row;
    status_o.bank      = addr_bank;
    status_o.col       = addr_col;
    status_o.bank_open = open_q[addr_bank];
    // Hit needs both the flag and a matching row
    status_o.row_hit   = open_q[addr_bank] && (row_q[addr_bank] == addr_row);
    status_o.any_open  = |open_q;
  end

  // Activate on an open bank means the FSM skipped a precharge
  a_activate_closed : assert property (
    @(posedge clock) disable iff (reset)
    update_i.activate |-> !open_q[addr_bank]
  ) else $error("%0t open_q[%0d]: expected 0 on activate, got 1", $time, addr_bank);

endmodule

// ==== ddr3_cmd_fsm.sv ====
`timescale 1ns/100ps
`include "ddr3_ctrl_params.svh"

module ddr3_cmd_fsm (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             cfg_enable_i,
  input  logic                             mem_rd_i,
  input  logic                             mem_wr_i,
  input  logic                             cmd_accept_i,
  input  ddr3_ctrl_pkg::refresh_status_t   refresh_i,
  input  ddr3_ctrl_pkg::bank_status_t      bank_i,
  output ddr3_ctrl_pkg::bank_update_t      update_o,
  output logic                             refresh_done_o,
  output logic                             mem_accept_o,
  output ddr3_ctrl_pkg::dfi_cmd_t          cmd_o
);

  import ddr3_ctrl_pkg::*;

  // Steps 0..5 are MR2, MR3, MR1, MR0, ZQCL, PREA
  localparam logic [2:0] INIT_DONE = 3'd6;

  ctrl_state_e state_q;
  ctrl_state_e state_next;
  ctrl_state_e target_q;
  ctrl_state_e target_next;
  ctrl_state_e access_state;
  logic [2:0]  init_step_q;
  logic [2:0]  init_step_next;
  dfi_cmd_t    init_cmd_q;
  dfi_cmd_t    init_cmd_next;
  logic        mem_req;

  assign mem_req = mem_rd_i | mem_wr_i;

  // Reads win when both are raised
  always_comb begin
    if (mem_rd_i) begin
      access_state = STATE_READ;
    end else begin
      access_state = STATE_WRITE;
    end
  end

  // ----------------------------------------------------------
  // Init sequence
  // ----------------------------------------------------------
  // Command is registered so it holds under back-pressure
  always_comb begin
    init_step_next = init_step_q + ((init_cmd_q.command != CMD_NOP) ? 3'd1 : 3'd0);
    init_cmd_next         = '0;
    init_cmd_next.command = CMD_NOP;
    // CKE release is sticky
    init_cmd_next.cke     = init_cmd_q.cke || (refresh_i.count <= `DDR_CKE_COUNT);
    case (init_step_next)
      3'd0: if (refresh_i.count <= `DDR_MR2_COUNT) begin
        init_cmd_next.command = CMD_LOAD_MODE;
        init_cmd_next.bank    = 3'd2;
        init_cmd_next.address = `DDR_MR2_VAL;
      end
      3'd1: if (refresh_i.count <= `DDR_MR3_COUNT) begin
        init_cmd_next.command = CMD_LOAD_MODE;
        init_cmd_next.bank    = 3'd3;
        init_cmd_next.address = `DDR_MR3_VAL;
      end
      3'd2: if (refresh_i.count <= `DDR_MR1_COUNT) begin
        init_cmd_next.command = CMD_LOAD_MODE;
        init_cmd_next.bank    = 3'd1;
        init_cmd_next.address = `DDR_MR1_VAL;
      end
      3'd3: if (refresh_i.count <= `DDR_MR0_COUNT) begin
        init_cmd_next.command = CMD_LOAD_MODE;
        init_cmd_next.bank    = 3'd0;
        init_cmd_next.address = `DDR_MR0_VAL;
      end
      // Long ZQ calibration
      3'd4: if (refresh_i.count <= `DDR_ZQCL_COUNT) begin
        init_cmd_next.command              = CMD_ZQCL;
        init_cmd_next.address[`DDR_A10]    = 1'b1;
      end
      // Precharge all, also if the timer already wrapped
      3'd5: if (refresh_i.count <= `DDR_PREA_COUNT || refresh_i.pending) begin
        init_cmd_next.command              = CMD_PRECHARGE;
        init_cmd_next.address[`DDR_A10]    = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      init_step_q        <= '0;
      init_cmd_q         <= '0;
      init_cmd_q.command <= CMD_NOP;
    end else if (cmd_accept_i && state_q == STATE_INIT) begin
      init_step_q <= init_step_next;
      init_cmd_q  <= init_cmd_next;
    end
  end

  // ----------------------------------------------------------
  // Next state
  // ----------------------------------------------------------
  always_comb begin
    state_next  = state_q;
    target_next = target_q;
    case (state_q)
      // Leave once init is done and the first refresh is due
      STATE_INIT: if (init_step_q == INIT_DONE && refresh_i.pending) begin
        state_next = STATE_IDLE;
      end
      STATE_IDLE: begin
        // Refresh first, rows closed ahead of it
        if (refresh_i.pending) begin
          target_next = STATE_REFRESH;
          if (bank_i.any_open) begin
            state_next = STATE_PRECHARGE;
          end else begin
            state_next = STATE_REFRESH;
          end
        end else if (cfg_enable_i && mem_req) begin
          if (bank_i.row_hit) begin
            state_next = access_state;
          end else if (bank_i.bank_open) begin
            // Row conflict
            state_next  = STATE_PRECHARGE;
            target_next = access_state;
          end else begin
            state_next  = STATE_ACTIVATE;
            target_next = access_state;
          end
        end
      end
      // Dropped enable abandons the request
      STATE_ACTIVATE: begin
        if (cfg_enable_i) begin
          state_next = target_q;
        end else begin
          state_next = STATE_IDLE;
        end
      end
      STATE_PRECHARGE: begin
        if (target_q == STATE_REFRESH) begin
          state_next = STATE_REFRESH;
        end else begin
          state_next = STATE_ACTIVATE;
        end
      end
      default: state_next = STATE_IDLE;
    endcase
  end

  // Advance only when the sequencer takes the command
  always_ff @(posedge clock) begin
    if (reset) begin
      state_q  <= STATE_INIT;
      target_q <= STATE_IDLE;
    end else if (cmd_accept_i) begin
      state_q  <= state_next;
      target_q <= target_next;
    end
  end

  // ----------------------------------------------------------
  // Command build
  // ----------------------------------------------------------
  always_comb begin
    cmd_o         = '0;
    cmd_o.cke     = 1'b1;
    cmd_o.command = CMD_NOP;
    case (state_q)
      STATE_INIT: cmd_o = init_cmd_q;
      STATE_ACTIVATE: if (cfg_enable_i) begin
        cmd_o.command = CMD_ACTIVE;
        cmd_o.bank    = bank_i.bank;
        cmd_o.address = bank_i.row;
      end
      STATE_READ, STATE_WRITE: if (cfg_enable_i) begin
        if (state_q == STATE_READ) begin
          cmd_o.command = CMD_READ;
        end else begin
          cmd_o.command = CMD_WRITE;
        end
        cmd_o.bank             = bank_i.bank;
        cmd_o.address          = {{(`DDR_ROW_W - `DDR_COL_W){1'b0}}, bank_i.col};
        // No auto-precharge
        cmd_o.address[`DDR_A10] = 1'b0;
      end
      STATE_PRECHARGE: begin
        cmd_o.command = CMD_PRECHARGE;
        if (target_q == STATE_REFRESH) begin
          cmd_o.address[`DDR_A10] = 1'b1;
        end else begin
          cmd_o.bank = bank_i.bank;
        end
      end
      STATE_REFRESH: cmd_o.command = CMD_REFRESH;
      default: ;
    endcase
  end

  // ----------------------------------------------------------
  // Strobes on accepted commands
  // ----------------------------------------------------------
  always_comb begin
    update_o.activate  = cmd_accept_i && (cmd_o.command == CMD_ACTIVE);
    update_o.close_one = cmd_accept_i && (cmd_o.command == CMD_PRECHARGE) &&
                         !cmd_o.address[`DDR_A10];
    update_o.close_all = cmd_accept_i && (cmd_o.command == CMD_PRECHARGE) &&
                         cmd_o.address[`DDR_A10];
  end

  assign refresh_done_o = cmd_accept_i && (cmd_o.command == CMD_REFRESH);
  assign mem_accept_o   = cmd_accept_i &&
                          (cmd_o.command == CMD_READ || cmd_o.command == CMD_WRITE);

  // Tracker must already show the row open when the access goes out
  a_access_on_hit : assert property (
    @(posedge clock) disable iff (reset)
    (cmd_accept_i && (cmd_o.command == CMD_READ || cmd_o.command == CMD_WRITE))
      |-> bank_i.row_hit
  ) else $error("%0t row_hit: expected 1 on access, got 0", $time);

  a_refresh_all_closed : assert property (
    @(posedge clock) disable iff (reset)
    (cmd_accept_i && cmd_o.command == CMD_REFRESH) |-> !bank_i.any_open
  ) else $error("%0t any_open: expected 0 on refresh, got 1", $time);

endmodule

// ==== ddr3_ctrl_top.sv ====
`timescale 1ns/100ps
`include "ddr3_ctrl_params.svh"

module ddr3_ctrl_top (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      cfg_enable_i,
  input  logic                      mem_rd_i,
  input  logic                      mem_wr_i,
  input  logic [`DDR_ADDR_W-1:0]    mem_addr_i,
  input  logic                      cmd_accept_i,
  output logic                      mem_accept_o,
  output ddr3_ctrl_pkg::dfi_cmd_t   cmd_o
);

  import ddr3_ctrl_pkg::*;

  // ----------------------------------------------------------
  // Internal links
  // ----------------------------------------------------------
  refresh_status_t refresh_status;
  bank_status_t    bank_status;
  bank_update_t    bank_update;
  logic            refresh_done;

  // Power-up delay and refresh interval
  ddr3_refresh_timer i_refresh_timer (
    .clock          (clock),
    .reset          (reset),
    .refresh_done_i (refresh_done),
    .status_o       (refresh_status)
  );

  // Address split and open rows
  ddr3_bank_tracker i_bank_tracker (
    .clock        (clock),
    .reset        (reset),
    .cfg_enable_i (cfg_enable_i),
    .mem_addr_i   (mem_addr_i),
    .update_i     (bank_update),
    .status_o     (bank_status)
  );

  // Scheduler
  ddr3_cmd_fsm i_cmd_fsm (
    .clock          (clock),
    .reset          (reset),
    .cfg_enable_i   (cfg_enable_i),
    .mem_rd_i       (mem_rd_i),
    .mem_wr_i       (mem_wr_i),
    .cmd_accept_i   (cmd_accept_i),
    .refresh_i      (refresh_status),
    .bank_i         (bank_status),
    .update_o       (bank_update),
    .refresh_done_o (refresh_done),
    .mem_accept_o   (mem_accept_o),
    .cmd_o          (cmd_o)
  );

endmodule

// ==== tb_ddr3_ctrl.sv ====
`timescale 1ns/100ps
`include "ddr3_ctrl_params.svh"

module tb_ddr3_ctrl;

  import ddr3_ctrl_pkg::*;

  // ----------------------------------------------------------
  // Run limits
  // ----------------------------------------------------------
  localparam int SEED          = 89924;
  // Power-up wait, 23 refresh intervals, some slack
  localparam int RUN_LIMIT     = `DDR_START_DELAY + 23 * `DDR_REFRESH_CYCLES + 200;
  // First request sits through the whole init
  localparam int STALL_LIMIT   = `DDR_START_DELAY + 2 * `DDR_REFRESH_CYCLES;
  localparam int EN_OFF_START  = 6000;
  localparam int EN_OFF_CYCLES = 50;

  logic                   clock;
  logic                   reset;
  logic                   cfg_enable_i;
  logic                   mem_rd_i;
  logic                   mem_wr_i;
  logic [`DDR_ADDR_W-1:0] mem_addr_i;
  logic                   cmd_accept_i;
  logic                   mem_accept_o;
  dfi_cmd_t               cmd_o;

  // Fields of the request being held
  logic [`DDR_ROW_W-1:0]  req_row;
  logic [`DDR_BANK_W-1:0] req_bank;
  logic [`DDR_COL_W-1:0]  req_col;
  logic [`DDR_ROW_W-1:0]  col_addr;

  // Reference open-row table
  logic [`DDR_ROW_W-1:0]  model_row [`DDR_BANKS];
  logic [`DDR_BANKS-1:0]  model_open;

  int       run_cycles;
  int       init_idx;
  int       refresh_count;
  int       access_count;
  int       value_errors = 0;
  int       other_errors = 0;
  logic     took_req;
  logic     prev_accept;
  logic     prev_enable;
  dfi_cmd_t prev_cmd;
  logic     is_access;
  logic     row_cmd;
  ddr_cmd_e expected_kind;

  ddr3_ctrl_top i_ddr3_ctrl_top (
    .clock        (clock),
    .reset        (reset),
    .cfg_enable_i (cfg_enable_i),
    .mem_rd_i     (mem_rd_i),
    .mem_wr_i     (mem_wr_i),
    .mem_addr_i   (mem_addr_i),
    .cmd_accept_i (cmd_accept_i),
    .mem_accept_o (mem_accept_o),
    .cmd_o        (cmd_o)
  );

  always #2 clock = ~clock;

  assign is_access     = (cmd_o.command == CMD_READ) || (cmd_o.command == CMD_WRITE);
  assign row_cmd       = is_access || (cmd_o.command == CMD_ACTIVE);
  // Read wins when both strobes are up
  assign expected_kind = mem_rd_i ? CMD_READ : CMD_WRITE;
  // Column on the low address bits, A10 stays low
  assign col_addr      = {{(`DDR_ROW_W - `DDR_COL_W){1'b0}}, req_col};

  // ----------------------------------------------------------
  // Bookkeeping and reference model
  // ----------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      run_cycles    <= 0;
      init_idx      <= 0;
      refresh_count <= 0;
      access_count  <= 0;
    end else begin
      run_cycles <= run_cycles + 1;
      if (cmd_accept_i && cmd_o.command != CMD_NOP && init_idx < 6) begin
        init_idx <= init_idx + 1;
      end
      if (cmd_accept_i && cmd_o.command == CMD_REFRESH) begin
        refresh_count <= refresh_count + 1;
      end
      if (mem_accept_o) begin
        access_count <= access_count + 1;
      end
    end
    took_req    <= mem_accept_o;
    prev_accept <= cmd_accept_i;
    prev_enable <= cfg_enable_i;
    prev_cmd    <= cmd_o;
  end

  // Open rows as seen from the accepted commands
  always_ff @(posedge clock) begin
    if (reset || !cfg_enable_i) begin
      model_open <= '0;
    end else if (cmd_accept_i && cmd_o.command == CMD_ACTIVE) begin
      model_open[cmd_o.bank] <= 1'b1;
      model_row[cmd_o.bank]  <= cmd_o.address;
    end else if (cmd_accept_i && cmd_o.command == CMD_PRECHARGE) begin
      if (cmd_o.address[`DDR_A10]) begin
        model_open <= '0;
      end else begin
        model_open[cmd_o.bank] <= 1'b0;
      end
    end
  end

  task automatic report_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    $display("Error at %0.1f ns: %s expected 0x%0h, got 0x%0h",
             $realtime, name, expected, actual);
    value_errors++;
  endtask

  // MR2, MR3, MR1, MR0, then ZQCL and precharge-all
  function automatic dfi_cmd_t expected_init(input int idx);
    dfi_cmd_t c;
    c     = '0;
    c.cke = 1'b1;
    case (idx)
      0: begin
        c.command = CMD_LOAD_MODE;
        c.bank    = 3'd2;
        c.address = `DDR_MR2_VAL;
      end
      1: begin
        c.command = CMD_LOAD_MODE;
        c.bank    = 3'd3;
        c.address = `DDR_MR3_VAL;
      end
      2: begin
        c.command = CMD_LOAD_MODE;
        c.bank    = 3'd1;
        c.address = `DDR_MR1_VAL;
      end
      3: begin
        c.command = CMD_LOAD_MODE;
        c.bank    = 3'd0;
        c.address = `DDR_MR0_VAL;
      end
      4: begin
        c.command            = CMD_ZQCL;
        c.address[`DDR_A10]  = 1'b1;
      end
      default: begin
        c.command            = CMD_PRECHARGE;
        c.address[`DDR_A10]  = 1'b1;
      end
    endcase
    return c;
  endfunction

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  // CKE held low until the count passes the release point
  a_cke_low_early : assert property (@(posedge clock) disable iff (reset)
    (run_cycles < (`DDR_START_DELAY - `DDR_CKE_COUNT)) |-> !cmd_o.cke
  ) else report_value("cmd_o.cke", 0, cmd_o.cke);

  a_cke_on_command : assert property (@(posedge clock) disable iff (reset)
    (cmd_o.command != CMD_NOP) |-> cmd_o.cke
  ) else report_value("cmd_o.cke", 1, cmd_o.cke);

  a_init_order : assert property (@(posedge clock) disable iff (reset)
    (cmd_accept_i && cmd_o.command != CMD_NOP && init_idx < 6)
      |-> (cmd_o == expected_init(init_idx))
  ) else report_value("cmd_o", expected_init(init_idx), cmd_o);

  a_no_early_access : assert property (@(posedge clock) disable iff (reset)
    (refresh_count == 0) |-> (!row_cmd && !mem_accept_o)
  ) else report_value("cmd_o.command before first refresh", CMD_NOP, cmd_o.command);

  a_activate_closed : assert property (@(posedge clock) disable iff (reset)
    (cmd_accept_i && cmd_o.command == CMD_ACTIVE) |-> !model_open[cmd_o.bank]
  ) else report_value("model_open[cmd_o.bank]", 0, model_open[cmd_o.bank]);

  a_access_open_row : assert property (@(posedge clock) disable iff (reset)
    (cmd_accept_i && is_access)
      |-> (model_open[cmd_o.bank] && model_row[cmd_o.bank] == req_row)
  ) else report_value("open row of cmd_o.bank", req_row, model_row[cmd_o.bank]);

  a_access_target : assert property (@(posedge clock) disable iff (reset)
    is_access |-> ({cmd_o.bank, cmd_o.address} == {req_bank, col_addr})
  ) else report_value("cmd_o bank and address", {req_bank, col_addr},
                      {cmd_o.bank, cmd_o.address});

  // Accept pulse exactly on the matching access
  a_accept_match : assert property (@(posedge clock) disable iff (reset)
    mem_accept_o == (cmd_accept_i && cmd_o.command == expected_kind)
  ) else report_value("mem_accept_o", cmd_accept_i && cmd_o.command == expected_kind,
                      mem_accept_o);

  a_refresh_closed : assert property (@(posedge clock) disable iff (reset)
    (cmd_accept_i && cmd_o.command == CMD_REFRESH) |-> (model_open == '0)
  ) else report_value("model_open on refresh", 0, model_open);

  // Back-pressure freezes the command
  a_hold_cmd : assert property (@(posedge clock) disable iff (reset)
    (!prev_accept && cfg_enable_i == prev_enable) |-> (cmd_o == prev_cmd)
  ) else report_value("cmd_o", prev_cmd, cmd_o);

  a_hold_accept : assert property (@(posedge clock) disable iff (reset)
    !cmd_accept_i |-> !mem_accept_o
  ) else report_value("mem_accept_o", 0, mem_accept_o);

  a_enable_low : assert property (@(posedge clock) disable iff (reset)
    !cfg_enable_i |-> !row_cmd
  ) else report_value("cmd_o.command with enable low", CMD_NOP, cmd_o.command);

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  task automatic drive_bus_controls();
    forever begin
      @(posedge clock);
      #0.5;
      // Sequencer takes about three in four commands
      cmd_accept_i = ($urandom % 4) != 0;
      cfg_enable_i = !(run_cycles >= EN_OFF_START &&
                       run_cycles < EN_OFF_START + EN_OFF_CYCLES);
    end
  endtask

  // Few rows in few banks so hits, misses and conflicts all show up
  task automatic issue_request();
    logic [`DDR_COL_W-1:0] col;
    int                    op;
    int                    wait_cycles;
    int                    gap;
    req_row  = `DDR_ROW_W'($urandom % 3);
    req_bank = `DDR_BANK_W'($urandom % 4);
    col      = `DDR_COL_W'($urandom);
    // Burst of 8 drops the low column bits
    req_col  = {col[`DDR_COL_W-1:3], 3'b000};
    op       = $urandom % 4;
    // Row, bank, column over a one-bit byte offset, top three bits spare
    mem_addr_i = {3'b000, req_row, req_bank, col, 1'b0};
    mem_rd_i   = (op != 2);
    mem_wr_i   = (op >= 2);
    wait_cycles = 0;
    do begin
      @(posedge clock);
      #0.5;
      wait_cycles++;
    end while (!took_req && wait_cycles < STALL_LIMIT && run_cycles < RUN_LIMIT);
    if (!took_req && wait_cycles >= STALL_LIMIT) begin
      $display("Request to bank %0d row %0d was not accepted within %0d cycles",
               req_bank, req_row, STALL_LIMIT);
      other_errors++;
    end
    mem_rd_i = 1'b0;
    mem_wr_i = 1'b0;
    gap = $urandom % 4;
    repeat (gap) begin
      @(posedge clock);
      #0.5;
    end
  endtask

  task automatic check_refresh_total();
    int min_refresh;
    min_refresh = (run_cycles - `DDR_START_DELAY) / `DDR_REFRESH_CYCLES - 1;
    if (refresh_count < min_refresh) begin
      $display("Only %0d refreshes were issued where at least %0d were due",
               refresh_count, min_refresh);
      other_errors++;
    end
    if (access_count == 0) begin
      $display("No read or write request was ever accepted");
      other_errors++;
    end
  endtask

  task automatic print_error_counts();
    $display("Error counts: %0d value, %0d other, %0d refreshes, %0d accesses",
             value_errors, other_errors, refresh_count, access_count);
  endtask

  initial begin
    void'($urandom(SEED));
    clock        = 1'b0;
    reset        = 1'b1;
    cfg_enable_i = 1'b1;
    mem_rd_i     = 1'b0;
    mem_wr_i     = 1'b0;
    mem_addr_i   = '0;
    cmd_accept_i = 1'b0;
    fork
      drive_bus_controls();
    join_none
    repeat (16) @(posedge clock);
    #0.5;
    reset = 1'b0;
    while (run_cycles < RUN_LIMIT) begin
      issue_request();
    end
    check_refresh_total();
    print_error_counts();
    if (value_errors == 0 && other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Backstop if the request loop never returns
  always @(posedge clock) begin
    if (run_cycles > RUN_LIMIT + STALL_LIMIT) begin
      $display("Run did not end within %0d cycles", RUN_LIMIT + STALL_LIMIT);
      print_error_counts();
      $display("Finished with errors");
      $finish;
    end
  end

endmodule

// ==== filelist.f ====
+incdir+.
ddr3_ctrl_pkg.sv
ddr3_refresh_timer.sv
ddr3_bank_tracker.sv
ddr3_cmd_fsm.sv
ddr3_ctrl_top.sv
tb_ddr3_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module tb_ddr3_ctrl \
  && { ./obj_dir/Vtb_ddr3_ctrl > sim.log 2>&1; cat sim.log; } \
  && ! grep -q "Finished with errors" sim.log \
  && grep -q "Finished with no errors" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
